/* bench/l2_mem_tb_table.svh */
// L2 testbench request table
`ifndef L2_MEM_TB_TABLE_SVH
`define L2_MEM_TB_TABLE_SVH

  // Each row gives test, write flag, address, write data, byte enable,
  // expected read data and expected error flag
  task automatic load_table();
    // Full word write then read back
    add_entry(1, 1'b1, 32'h0000_0040, 32'hDEAD_BEEF, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(1, 1'b0, 32'h0000_0040, 32'h0000_0000, 4'hF, 32'hDEAD_BEEF, 1'b0);
    // One word in each bank issued back to back
    add_entry(2, 1'b1, 32'h0000_0100, 32'hA0A0_0001, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(2, 1'b1, 32'h0000_0104, 32'hB1B1_0002, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(2, 1'b1, 32'h0000_0108, 32'hC2C2_0003, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(2, 1'b1, 32'h0000_010C, 32'hD3D3_0004, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(2, 1'b0, 32'h0000_0100, 32'h0000_0000, 4'hF, 32'hA0A0_0001, 1'b0);
    add_entry(2, 1'b0, 32'h0000_0104, 32'h0000_0000, 4'hF, 32'hB1B1_0002, 1'b0);
    add_entry(2, 1'b0, 32'h0000_0108, 32'h0000_0000, 4'hF, 32'hC2C2_0003, 1'b0);
    add_entry(2, 1'b0, 32'h0000_010C, 32'h0000_0000, 4'hF, 32'hD3D3_0004, 1'b0);
    // Partial writes keep the disabled bytes
    add_entry(3, 1'b1, 32'h0000_0200, 32'h1122_3344, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(3, 1'b1, 32'h0000_0200, 32'hAABB_CCDD, 4'h5, 32'h0000_0000, 1'b0);
    add_entry(3, 1'b0, 32'h0000_0200, 32'h0000_0000, 4'hF, 32'h11BB_33DD, 1'b0);
    add_entry(3, 1'b1, 32'h0000_0204, 32'h5566_7788, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(3, 1'b1, 32'h0000_0204, 32'hEE00_0000, 4'h8, 32'h0000_0000, 1'b0);
    add_entry(3, 1'b0, 32'h0000_0204, 32'h0000_0000, 4'hF, 32'hEE66_7788, 1'b0);
    // Out of range accesses leave the aliasing in-range words unchanged
    add_entry(4, 1'b1, 32'h0000_1040, 32'hBAD0_BAD0, 4'hF, 32'h0000_0000, 1'b1);
    add_entry(4, 1'b0, 32'h0000_1040, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b1);
    add_entry(4, 1'b0, 32'h0000_0040, 32'h0000_0000, 4'hF, 32'hDEAD_BEEF, 1'b0);
    add_entry(4, 1'b1, 32'h8000_0104, 32'h0BAD_F00D, 4'hF, 32'h0000_0000, 1'b1);
    add_entry(4, 1'b0, 32'h0000_0104, 32'h0000_0000, 4'hF, 32'hB1B1_0002, 1'b0);
    // Mixed burst under back-pressure
    add_entry(5, 1'b1, 32'h0000_03F0, 32'h0123_4567, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(5, 1'b1, 32'h0000_03F4, 32'h89AB_CDEF, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(5, 1'b1, 32'h0000_03F8, 32'hFEDC_BA98, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(5, 1'b1, 32'h0000_03FC, 32'h7654_3210, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(5, 1'b0, 32'h0000_03FC, 32'h0000_0000, 4'hF, 32'h7654_3210, 1'b0);
    add_entry(5, 1'b0, 32'h0000_03F0, 32'h0000_0000, 4'hF, 32'h0123_4567, 1'b0);
    add_entry(5, 1'b0, 32'h0000_03F8, 32'h0000_0000, 4'hF, 32'hFEDC_BA98, 1'b0);
    add_entry(5, 1'b0, 32'h0000_03F4, 32'h0000_0000, 4'hF, 32'h89AB_CDEF, 1'b0);
    add_entry(5, 1'b1, 32'h0000_0FFC, 32'h0F0F_F0F0, 4'hF, 32'h0000_0000, 1'b0);
    add_entry(5, 1'b0, 32'h0000_0FFC, 32'h0000_0000, 4'hF, 32'h0F0F_F0F0, 1'b0);
    add_entry(5, 1'b0, 32'h0000_1000, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b1);
    add_entry(5, 1'b0, 32'h0000_0200, 32'h0000_0000, 4'hF, 32'h11BB_33DD, 1'b0);
  endtask

`endif

/* bench/l2_mem_tb.sv */
// L2 scratchpad testbench
`timescale 1ns/1ns
`default_nettype none

module l2_mem_tb;

  import l2_cfg_pkg::*;
  import l2_bus_pkg::*;

  localparam int unsigned BankWords = 256;
  localparam int          Credits   = 4;
  localparam int          NumTests  = 5;

  typedef struct packed {
    logic [3:0]           test;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] exp_rdata;
    logic                 exp_err;
  } test_entry_t;

  logic     clk_i;
  logic     rst_i;
  logic     req_valid_i;
  l2_req_t  req_i;
  logic     resp_valid_o;
  l2_resp_t resp_o;
  logic     resp_ready_i;
  logic     credit_o;

  test_entry_t tbl [$];
  int          exp_q [$];
  int          test_errs [1:NumTests];
  int          credits;
  int          credit_pulses;
  int          credit_errs;
  int          checked;
  int          errors;

  l2_interleaved_mem #(
    .BANK_WORDS ( BankWords ),
    .CREDITS    ( Credits   )
  ) u_dut (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .resp_valid_o ( resp_valid_o ),
    .resp_o       ( resp_o       ),
    .resp_ready_i ( resp_ready_i ),
    .credit_o     ( credit_o     )
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  function automatic string test_title(input int id);
    case (id)
      1:       return "full word write and read";
      2:       return "bank interleaving";
      3:       return "byte enable merge";
      4:       return "out of range access";
      default: return "back-pressure and credits";
    endcase
  endfunction

  task automatic add_entry(input int test, input logic we, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be,
                           input logic [31:0] exp_rdata, input logic exp_err);
    test_entry_t e;
    e.test      = test[3:0];
    e.we        = we;
    e.addr      = addr;
    e.wdata     = wdata;
    e.be        = be;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    tbl.push_back(e);
  endtask

  `include "l2_mem_tb_table.svh"

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Requests, credit tracking and random response back-pressure
  initial begin : drive
    test_entry_t e;
    l2_req_t     req;
    int          next_req;
    int          passed;
    int          failed;
    logic [31:0] lfsr_q;
    logic        ready_bit;
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_i        = '0;
    resp_ready_i = 1'b0;
    load_table();
    credits  = Credits;
    lfsr_q   = 32'h01d6_41c2;
    next_req = 0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    while (next_req < tbl.size() || checked < tbl.size()) begin
      @(posedge clk_i);
      if (credit_o) begin
        credits = credits + 1;
        credit_pulses++;
      end
      if (credits < 0 || credits > Credits) begin
        $display("[ERROR] %0t: credit count %0d out of range", $time, credits);
        credit_errs++;
      end
      if (next_req < tbl.size() && credits > 0) begin
        e              = tbl[next_req];
        req.we         = e.we;
        req.addr.flat  = e.addr;
        req.wdata      = e.wdata;
        req.be         = e.be;
        req_valid_i   <= 1'b1;
        req_i         <= req;
        exp_q.push_back(next_req);
        credits        = credits - 1;
        next_req++;
      end else begin
        req_valid_i <= 1'b0;
      end
      // Two LFSR bits ORed for ready about three quarters of the time
      lfsr_q        = lfsr_step(lfsr_q);
      ready_bit     = lfsr_q[0];
      lfsr_q        = lfsr_step(lfsr_q);
      resp_ready_i <= ready_bit | lfsr_q[0];
    end
    if (credit_pulses != checked) begin
      $display("[ERROR] %0t: %0d credit pulses for %0d responses", $time, credit_pulses,
               checked);
      credit_errs++;
    end
    if (credits != Credits) begin
      $display("[ERROR] %0t: %0d credits held at the end", $time, credits);
      credit_errs++;
    end
    passed = 0;
    failed = 0;
    for (int t = 1; t <= NumTests; t++) begin
      if (test_errs[t] != 0 || (t == NumTests && credit_errs != 0)) begin
        failed++;
      end else begin
        passed++;
      end
    end
    $display("Tests passed %0d, failed %0d", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Responses are checked in table order at each transfer
  always @(posedge clk_i) begin : check_resp
    int          idx;
    int          errs;
    test_entry_t e;
    if (!rst_i && resp_valid_o && resp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A response arrived at %0t with no request outstanding", $time);
        errors++;
      end else begin
        idx = exp_q.pop_front();
        e   = tbl[idx];
        if (resp_o.rdata !== e.exp_rdata) begin
          $display("[ERROR] %0t: entry %0d read data %h, expected %h", $time, idx,
                   resp_o.rdata, e.exp_rdata);
          test_errs[e.test]++;
        end
        if (resp_o.err !== e.exp_err) begin
          $display("[ERROR] %0t: entry %0d error flag %b, expected %b", $time, idx,
                   resp_o.err, e.exp_err);
          test_errs[e.test]++;
        end
        if (credit_o !== 1'b1) begin
          $display("[ERROR] %0t: entry %0d response without a credit pulse", $time, idx);
          test_errs[e.test]++;
        end
        checked++;
        if (idx == tbl.size() - 1 || tbl[idx + 1].test != e.test) begin
          errs = test_errs[e.test] + ((e.test == NumTests) ? credit_errs : 0);
          $display("Test %0d %s: %s", e.test, test_title(e.test),
                   (errs == 0) ? "PASS" : "FAIL");
        end
      end
    end
  end

  // Watchdog sized from the table length
  initial begin
    #1;
    repeat (tbl.size() * 20) @(posedge clk_i);
    $display("Run timed out waiting for responses, %0d of %0d checked", checked,
             tbl.size());
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+bench
rtl/l2_cfg_pkg.sv
rtl/l2_bus_pkg.sv
rtl/l2_req_dispatch.sv
rtl/l2_bank.sv
rtl/l2_resp_merge.sv
rtl/l2_interleaved_mem.sv
bench/l2_mem_tb.sv

/* rtl/l2_bank.sv */
// L2 single-port SRAM bank
`timescale 1ns/1ns
`default_nettype none

module l2_bank #(
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                              clk_i,
  input  logic                              bank_valid_i,
  input  l2_bus_pkg::l2_bank_req_t          bank_req_i,
  output logic [l2_cfg_pkg::DataWidth-1:0]  bank_rdata_o
);

  import l2_cfg_pkg::*;

  localparam int unsigned IdxBits = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  logic [DataWidth-1:0] mem_q [BANK_WORDS];
  logic [IdxBits-1:0]   idx;

  // Upper row bits were range checked by the dispatcher
  assign idx = bank_req_i.row[IdxBits-1:0];

  always_ff @(posedge clk_i) begin
    if (bank_valid_i) begin
      if (bank_req_i.we) begin
        // Only enabled byte lanes are written
        for (int b = 0; b < StrbWidth; b++) begin
          if (bank_req_i.be[b]) begin
            mem_q[idx][b*8 +: 8] <= bank_req_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        // Read data appears one cycle later and holds until the next read
        bank_rdata_o <= mem_q[idx];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/l2_bus_pkg.sv */
// L2 requester and bank bus types
`default_nettype none

package l2_bus_pkg;

  // Field view of a byte address with the bank in the low bits
  typedef struct packed {
    logic [l2_cfg_pkg::RowBits-1:0]     row;
    logic [l2_cfg_pkg::BankSelBits-1:0] bank;
    logic [l2_cfg_pkg::OffsetBits-1:0]  offset;
  } l2_addr_fields_t;

  // Same address word seen flat or split
  typedef union packed {
    logic [l2_cfg_pkg::AddrWidth-1:0] flat;
    l2_addr_fields_t                  fields;
  } l2_addr_u;

  // Request from the requester port
  typedef struct packed {
    logic                             we;
    l2_addr_u                         addr;
    logic [l2_cfg_pkg::DataWidth-1:0] wdata;
    logic [l2_cfg_pkg::StrbWidth-1:0] be;
  } l2_req_t;

  // Request as seen by a single bank
  typedef struct packed {
    logic                             we;
    logic [l2_cfg_pkg::RowBits-1:0]   row;
    logic [l2_cfg_pkg::DataWidth-1:0] wdata;
    logic [l2_cfg_pkg::StrbWidth-1:0] be;
  } l2_bank_req_t;

  // Response towards the requester
  typedef struct packed {
    logic [l2_cfg_pkg::DataWidth-1:0] rdata;
    logic                             err;
  } l2_resp_t;

endpackage

`default_nettype wire

/* rtl/l2_cfg_pkg.sv */
// L2 scratchpad geometry
`default_nettype none

package l2_cfg_pkg;

  // Word interleaving across the banks
  // The address field layout below depends on this count
  localparam int unsigned NumBanks    = 4;
  localparam int unsigned BankSelBits = 2;

  // Data word and its byte lanes
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;

  // Byte address split into row, bank and byte offset
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned OffsetBits  = 2;
  localparam int unsigned RowBits     = AddrWidth - BankSelBits - OffsetBits;

endpackage

`default_nettype wire

/* rtl/l2_interleaved_mem.sv */
// L2 interleaved scratchpad top
`timescale 1ns/1ns
`default_nettype none

module l2_interleaved_mem #(
  parameter int unsigned BANK_WORDS = 256,
  parameter int unsigned CREDITS    = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_valid_i,
  input  l2_bus_pkg::l2_req_t   req_i,
  output logic                  resp_valid_o,
  output l2_bus_pkg::l2_resp_t  resp_o,
  input  logic                  resp_ready_i,
  output logic                  credit_o
);

  import l2_cfg_pkg::*;
  import l2_bus_pkg::*;

  logic [NumBanks-1:0]                bank_valid;
  l2_bank_req_t                       bank_req;
  logic [NumBanks-1:0][DataWidth-1:0] bank_rdata;
  logic                               disp_valid;
  logic                               disp_err;
  logic                               disp_we;
  logic [BankSelBits-1:0]             disp_bank;

  l2_req_dispatch #(
    .BANK_WORDS ( BANK_WORDS )
  ) i_req_dispatch (
    .clk_i        ( clk_i       ),
    .rst_i        ( rst_i       ),
    .req_valid_i  ( req_valid_i ),
    .req_i        ( req_i       ),
    .bank_valid_o ( bank_valid  ),
    .bank_req_o   ( bank_req    ),
    .disp_valid_o ( disp_valid  ),
    .disp_err_o   ( disp_err    ),
    .disp_bank_o  ( disp_bank   ),
    .disp_we_o    ( disp_we     )
  );

  // One bank per word lane of the interleave
  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    l2_bank #(
      .BANK_WORDS ( BANK_WORDS )
    ) i_bank (
      .clk_i        ( clk_i         ),
      .bank_valid_i ( bank_valid[b] ),
      .bank_req_i   ( bank_req      ),
      .bank_rdata_o ( bank_rdata[b] )
    );
  end

  l2_resp_merge #(
    .CREDITS ( CREDITS )
  ) i_resp_merge (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .disp_valid_i ( disp_valid   ),
    .disp_err_i   ( disp_err     ),
    .disp_bank_i  ( disp_bank    ),
    .disp_we_i    ( disp_we      ),
    .bank_rdata_i ( bank_rdata   ),
    .resp_valid_o ( resp_valid_o ),
    .resp_o       ( resp_o       ),
    .resp_ready_i ( resp_ready_i ),
    .credit_o     ( credit_o     )
  );

endmodule

`default_nettype wire

/* rtl/l2_req_dispatch.sv */
// L2 request dispatcher
`timescale 1ns/1ns
`default_nettype none

module l2_req_dispatch #(
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                req_valid_i,
  input  l2_bus_pkg::l2_req_t                 req_i,
  output logic [l2_cfg_pkg::NumBanks-1:0]     bank_valid_o,
  output l2_bus_pkg::l2_bank_req_t            bank_req_o,
  output logic                                disp_valid_o,
  output logic                                disp_err_o,
  output logic [l2_cfg_pkg::BankSelBits-1:0]  disp_bank_o,
  output logic                                disp_we_o
);

  import l2_cfg_pkg::*;
  import l2_bus_pkg::*;

  // One bit wider than the row so a full-range bank count still fits
  localparam logic [RowBits:0] RowLimit = (RowBits + 1)'(BANK_WORDS);

  l2_addr_u req_addr;
  logic     out_of_range;

  assign req_addr.flat = req_i.addr.flat;
  assign out_of_range  = {1'b0, req_addr.fields.row} >= RowLimit;

  // Shared bank bus qualified per bank by its valid line
  assign bank_req_o.we    = req_i.we;
  assign bank_req_o.row   = req_addr.fields.row;
  assign bank_req_o.wdata = req_i.wdata;
  assign bank_req_o.be    = req_i.be;

  // Out-of-range requests touch no bank
  always_comb begin
    bank_valid_o = '0;
    if (req_valid_i && !out_of_range) begin
      bank_valid_o[req_addr.fields.bank] = 1'b1;
    end
  end

  // Delayed to meet the registered bank read data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      disp_valid_o <= 1'b0;
    end else begin
      disp_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      disp_err_o  <= out_of_range;
      disp_bank_o <= req_addr.fields.bank;
      disp_we_o   <= req_i.we;
    end
  end

endmodule

`default_nettype wire

/* rtl/l2_resp_merge.sv */
// L2 response merger and credit return
`timescale 1ns/1ns
`default_nettype none

module l2_resp_merge #(
  parameter int unsigned CREDITS = 4
) (
  input  logic                                                        clk_i,
  input  logic                                                        rst_i,
  input  logic                                                        disp_valid_i,
  input  logic                                                        disp_err_i,
  input  logic [l2_cfg_pkg::BankSelBits-1:0]                          disp_bank_i,
  input  logic                                                        disp_we_i,
  input  logic [l2_cfg_pkg::NumBanks-1:0][l2_cfg_pkg::DataWidth-1:0]  bank_rdata_i,
  output logic                                                        resp_valid_o,
  output l2_bus_pkg::l2_resp_t                                        resp_o,
  input  logic                                                        resp_ready_i,
  output logic                                                        credit_o
);

  import l2_bus_pkg::*;

  localparam int unsigned PtrBits = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int unsigned CntBits = $clog2(CREDITS + 1);

  l2_resp_t           queue_q [CREDITS];
  l2_resp_t           push_resp;
  logic [PtrBits-1:0] wr_ptr_q;
  logic [PtrBits-1:0] rd_ptr_q;
  logic [CntBits-1:0] count_q;
  logic               push;
  logic               pop;

  // Pointer wrap for any queue depth
  function automatic logic [PtrBits-1:0] next_ptr(input logic [PtrBits-1:0] ptr);
    if (ptr == PtrBits'(CREDITS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Only reads that hit a bank carry data
  always_comb begin
    push_resp.err   = disp_err_i;
    push_resp.rdata = '0;
    if (!disp_err_i && !disp_we_i) begin
      push_resp.rdata = bank_rdata_i[disp_bank_i];
    end
  end

  // Requester credits keep the queue from overflowing
  assign push = disp_valid_i;
  assign pop  = resp_valid_o && resp_ready_i;

  assign resp_valid_o = (count_q != '0);
  assign resp_o       = queue_q[rd_ptr_q];
  assign credit_o     = pop;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Queue storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= push_resp;
    end
  end

endmodule

`default_nettype wire
